// File: include/mem_macros.svh
// sizing macros for the pipelined memory model
// address width, capacity, tag count and load latency

`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// address space
////////////////////////////////////////////////////////////////////////////

// processor address width
`define MEM_XLEN 32

// capacity in bytes, addresses at or above are refused
`define MEM_SIZE_IN_BYTES 4096

// storage is organised as 64-bit lines
`define MEM_64BIT_LINES (`MEM_SIZE_IN_BYTES / 8)

////////////////////////////////////////////////////////////////////////////
// pipeline
////////////////////////////////////////////////////////////////////////////

// outstanding operations, tags 1..NUM_MEM_TAGS, tag 0 means none
`define NUM_MEM_TAGS 15

// cycles from response to load data on the return bus
`define MEM_LATENCY_IN_CYCLES 4

`endif

// File: verilog/mem_pkg.sv
// shared types for the memory model
// bus command, access size, transaction tag and line data

`include "mem_macros.svh"

package mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // processor bus encodings
    ////////////////////////////////////////////////////////////////////////////

    // command presented by the processor each cycle
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0, // idle cycle
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_t;

    // access width, alignment follows the size
    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_t;

    ////////////////////////////////////////////////////////////////////////////
    // data and tags
    ////////////////////////////////////////////////////////////////////////////

    // transaction tag, wide enough for tags 1..NUM_MEM_TAGS
    // zero on response or return bus means no transaction
    typedef logic [$clog2(`NUM_MEM_TAGS + 1)-1:0] mem_tag_t;

    // one storage line, also the width of both data buses
    typedef logic [63:0] mem_line_t;

endpackage

// File: verilog/mem_access_if.sv
// single-cycle access path from the tag tracker to the storage array
// stores commit at the next rising edge, load data is combinational

`timescale 1ns/1ps

`include "mem_macros.svh"

interface mem_access_if
    import mem_pkg::*;
();

    logic                 valid;   // access issued this cycle
    logic                 is_load; // clear for a store
    logic [`MEM_XLEN-1:0] addr;    // byte address, already range checked
    mem_size_t            size;
    mem_line_t            wdata;   // store data, low bits used for narrow sizes
    mem_line_t            rdata;   // extracted and zero-extended load data

    modport tracker (
        output valid,
        output is_load,
        output addr,
        output size,
        output wdata,
        input  rdata
    );

    modport storage (
        input  valid,
        input  is_load,
        input  addr,
        input  size,
        input  wdata,
        output rdata
    );

endinterface

// File: verilog/mem_storage.sv
// storage array of 64-bit lines
// size-aware store merging and zero-extended load extraction

`timescale 1ns/1ps

`include "mem_macros.svh"

module mem_storage
    import mem_pkg::*;
(
    input logic            clk,
    mem_access_if.storage  access
);

    localparam int LINE_IDX_W = $clog2(`MEM_64BIT_LINES);

    mem_line_t             mem_array [0:`MEM_64BIT_LINES-1];
    logic [LINE_IDX_W-1:0] line_idx;
    logic [2:0]            byte_off;   // position inside the line
    mem_line_t             cur_line;
    mem_line_t             merged_line;
    mem_line_t             load_val;

    assign line_idx = access.addr[LINE_IDX_W+2:3];
    assign byte_off = access.addr[2:0];
    assign cur_line = mem_array[line_idx];

    ////////////////////////////////////////////////////////////////////////////
    // load extraction
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        load_val = '0;
        case (access.size)
            BYTE: begin
                load_val[7:0] = cur_line[{byte_off, 3'b000} +: 8];
            end
            HALF: begin
                load_val[15:0] = cur_line[{byte_off[2:1], 4'b0000} +: 16];
            end
            WORD: begin
                load_val[31:0] = cur_line[{byte_off[2], 5'b00000} +: 32];
            end
            default: begin
                load_val = cur_line; // whole line
            end
        endcase
    end

    assign access.rdata = load_val;

    ////////////////////////////////////////////////////////////////////////////
    // store merging
    ////////////////////////////////////////////////////////////////////////////

    // only the addressed part of the line changes
    always_comb begin
        merged_line = cur_line;
        case (access.size)
            BYTE: begin
                merged_line[{byte_off, 3'b000} +: 8] = access.wdata[7:0];
            end
            HALF: begin
                merged_line[{byte_off[2:1], 4'b0000} +: 16] = access.wdata[15:0];
            end
            WORD: begin
                merged_line[{byte_off[2], 5'b00000} +: 32] = access.wdata[31:0];
            end
            default: begin
                merged_line = access.wdata;
            end
        endcase
    end

    always @(posedge clk) begin
        if (access.valid && !access.is_load) begin
            mem_array[line_idx] <= merged_line;
        end
    end

    // memory starts out all zero
    initial begin
        for (int i = 0; i < `MEM_64BIT_LINES; i++) begin
            mem_array[i] = '0;
        end
    end

endmodule

// File: verilog/mem_tag_tracker.sv
// command acceptance, tag allocation and per-tag latency counting
// lowest ready load wins the registered return bus each cycle

`timescale 1ns/1ps

`include "mem_macros.svh"

module mem_tag_tracker
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  bus_command_t         command,
    input  logic [`MEM_XLEN-1:0] addr,
    input  mem_size_t            size,
    input  mem_line_t            wdata,
    output mem_tag_t             response,
    output mem_line_t            ret_data,
    output mem_tag_t             ret_tag,
    mem_access_if.tracker        access
);

    localparam int CNT_W = $clog2(`MEM_LATENCY_IN_CYCLES + 1);

    // per-tag state, index 0 unused since tag 0 means none
    logic [`NUM_MEM_TAGS:1] busy;
    logic [`NUM_MEM_TAGS:1] waiting_for_bus;       // load data not yet delivered
    logic [CNT_W-1:0]       cycles_left [1:`NUM_MEM_TAGS];
    mem_line_t              loaded_data [1:`NUM_MEM_TAGS];

    logic     is_cmd;
    logic     in_range;
    logic     aligned;
    logic     accept;
    logic     free_found;
    mem_tag_t free_sel;
    logic     ret_found;
    mem_tag_t ret_sel;

    ////////////////////////////////////////////////////////////////////////////
    // acceptance
    ////////////////////////////////////////////////////////////////////////////

    assign is_cmd   = (command == BUS_LOAD) || (command == BUS_STORE);
    assign in_range = (addr < `MEM_SIZE_IN_BYTES);

    always_comb begin
        case (size)
            BYTE:    aligned = 1'b1;
            HALF:    aligned = (addr[0] == 1'b0);
            WORD:    aligned = (addr[1:0] == 2'b00);
            default: aligned = (addr[2:0] == 3'b000);
        endcase
    end

    // scan downward so the lowest free tag is left in free_sel
    always_comb begin
        free_found = 1'b0;
        free_sel   = '0;
        for (int i = `NUM_MEM_TAGS; i >= 1; i--) begin
            if (!busy[i]) begin
                free_found = 1'b1;
                free_sel   = mem_tag_t'(i);
            end
        end
    end

    assign accept = is_cmd && in_range && aligned && free_found;

    // every issued access completes in the same cycle
    assign access.valid   = accept;
    assign access.is_load = (command == BUS_LOAD);
    assign access.addr    = addr;
    assign access.size    = size;
    assign access.wdata   = wdata;

    ////////////////////////////////////////////////////////////////////////////
    // return arbitration
    ////////////////////////////////////////////////////////////////////////////

    // a load is ready on its last counted cycle, or later if it lost the bus
    always_comb begin
        ret_found = 1'b0;
        ret_sel   = '0;
        for (int i = `NUM_MEM_TAGS; i >= 1; i--) begin
            if (waiting_for_bus[i] && (cycles_left[i] <= CNT_W'(1))) begin
                ret_found = 1'b1;
                ret_sel   = mem_tag_t'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tag state and registered outputs
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy            <= '0;
            waiting_for_bus <= '0;
            for (int i = 1; i <= `NUM_MEM_TAGS; i++) begin
                cycles_left[i] <= '0;
            end
            response <= '0;
            ret_tag  <= '0;
            ret_data <= '0;
        end else begin
            for (int i = 1; i <= `NUM_MEM_TAGS; i++) begin
                if (cycles_left[i] != '0) begin
                    cycles_left[i] <= cycles_left[i] - CNT_W'(1);
                end
                // store releases its tag once the count runs out
                if (busy[i] && !waiting_for_bus[i] && (cycles_left[i] == CNT_W'(1))) begin
                    busy[i] <= 1'b0;
                end
            end

            if (ret_found) begin
                waiting_for_bus[ret_sel] <= 1'b0;
                busy[ret_sel]            <= 1'b0; // load tag freed on delivery
            end

            if (accept) begin
                busy[free_sel]            <= 1'b1;
                waiting_for_bus[free_sel] <= access.is_load;
                cycles_left[free_sel]     <= CNT_W'(`MEM_LATENCY_IN_CYCLES);
            end

            response <= accept ? free_sel : mem_tag_t'(0);
            ret_tag  <= ret_found ? ret_sel : mem_tag_t'(0);
            ret_data <= ret_found ? loaded_data[ret_sel] : mem_line_t'(0);
        end
    end

    // load data captured at acceptance
    always_ff @(posedge clk) begin
        if (accept && access.is_load) begin
            loaded_data[free_sel] <= access.rdata;
        end
    end

endmodule

// File: verilog/mem_top.sv
// top level of the tagged pipelined memory
// processor buses on plain ports, tracker and storage joined by one interface

`timescale 1ns/1ps

`include "mem_macros.svh"

module mem_top
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,

    // command/address and data-in buses
    input  bus_command_t         proc2mem_command,
    input  logic [`MEM_XLEN-1:0] proc2mem_addr,
    input  mem_size_t            proc2mem_size,
    input  mem_line_t            proc2mem_data,

    // response and tagged data-out bus
    output mem_tag_t             mem2proc_response, // 0 when refused
    output mem_line_t            mem2proc_data,
    output mem_tag_t             mem2proc_tag       // 0 when no return
);

    ////////////////////////////////////////////////////////////////////////////
    // internal access path
    ////////////////////////////////////////////////////////////////////////////

    mem_access_if u_access_if ();

    ////////////////////////////////////////////////////////////////////////////
    // tag tracking and return bus
    ////////////////////////////////////////////////////////////////////////////

    mem_tag_tracker u_mem_tag_tracker (
        .clk      (clk),
        .arst_n   (arst_n),
        .command  (proc2mem_command),
        .addr     (proc2mem_addr),
        .size     (proc2mem_size),
        .wdata    (proc2mem_data),
        .response (mem2proc_response),
        .ret_data (mem2proc_data),
        .ret_tag  (mem2proc_tag),
        .access   (u_access_if.tracker)
    );

    ////////////////////////////////////////////////////////////////////////////
    // storage array
    ////////////////////////////////////////////////////////////////////////////

    mem_storage u_mem_storage (
        .clk    (clk),
        .access (u_access_if.storage)
    );

endmodule

// File: bench/mem_sva.sv
// protocol assertions for the memory top level
// return tag reuse, idle-cycle responses and reset values, bound to mem_top

`timescale 1ns/1ps

`include "mem_macros.svh"

module mem_sva
    import mem_pkg::*;
(
    input logic         clk,
    input logic         arst_n,
    input bus_command_t proc2mem_command,
    input mem_tag_t     mem2proc_response,
    input mem_tag_t     mem2proc_tag,
    input mem_line_t    mem2proc_data
);

    // set when a tag returns, cleared by the next response carrying it
    logic [`NUM_MEM_TAGS:0] returned;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            returned <= '0;
        end else begin
            if (mem2proc_response != '0) begin
                returned[mem2proc_response] <= 1'b0;
            end
            if (mem2proc_tag != '0) begin
                returned[mem2proc_tag] <= 1'b1;
            end
        end
    end

    a_no_repeat: assert property (@(posedge clk) disable iff (!arst_n)
        (mem2proc_tag != '0) |-> !returned[mem2proc_tag])
        else $error("tag %0d returned again without a new response", mem2proc_tag);

    a_idle_no_response: assert property (@(posedge clk) disable iff (!arst_n)
        (proc2mem_command == BUS_NONE) |=> (mem2proc_response == '0))
        else $error("nonzero response for an idle cycle");

    a_reset_values: assert property (@(posedge clk)
        $rose(arst_n) |-> (mem2proc_response == '0) && (mem2proc_tag == '0)
                          && (mem2proc_data == '0))
        else $error("outputs not cleared by reset");

endmodule

bind mem_top mem_sva u_mem_sva (
    .clk               (clk),
    .arst_n            (arst_n),
    .proc2mem_command  (proc2mem_command),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data)
);

// File: bench/mem_tb.sv
// testbench for the tagged pipelined memory
// clock, reset, directed and random stimulus, shadow-memory reference,
// comparison process on the return bus and the closing report

`timescale 1ns/1ps

`include "mem_macros.svh"

module mem_tb
    import mem_pkg::*;
();

    logic                 clk;
    logic                 arst_n;
    bus_command_t         proc2mem_command;
    logic [`MEM_XLEN-1:0] proc2mem_addr;
    mem_size_t            proc2mem_size;
    mem_line_t            proc2mem_data;
    mem_tag_t             mem2proc_response;
    mem_line_t            mem2proc_data;
    mem_tag_t             mem2proc_tag;

    logic [7:0]             shadow [0:`MEM_SIZE_IN_BYTES-1]; // byte-wide reference memory
    mem_line_t              exp_data [1:`NUM_MEM_TAGS];      // recorded at load acceptance
    int                     resp_cycle [1:`NUM_MEM_TAGS];
    logic [`NUM_MEM_TAGS:1] outstanding;                     // loads not yet returned
    int                     pending;
    int                     loads_accepted;
    int                     cycle_cnt;
    bit                     check_alloc; // lowest-free check, load-only traffic
    mem_tag_t               resp_q [$];
    mem_tag_t               last_ret_tag;
    mem_line_t              last_ret_data;
    int                     last_latency;

    // command seen at the previous falling edge
    bus_command_t         prev_cmd = BUS_NONE;
    logic [`MEM_XLEN-1:0] prev_addr;
    mem_size_t            prev_size;
    mem_line_t            prev_data;

    string cur_test;
    int    errors;
    int    err_at_start;
    int    tests_run;
    int    tests_failed;

    mem_top u_mem_top (
        .clk               (clk),
        .arst_n            (arst_n),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_size     (proc2mem_size),
        .proc2mem_data     (proc2mem_data),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // little endian, zero-extended
    function automatic mem_line_t ref_load(input logic [`MEM_XLEN-1:0] addr,
                                           input mem_size_t size);
        mem_line_t v;
        v = '0;
        for (int i = 0; i < (1 << int'(size)); i++) begin
            v[8*i +: 8] = shadow[addr + i];
        end
        return v;
    endfunction

    task automatic write_shadow(input logic [`MEM_XLEN-1:0] addr, input mem_size_t size,
                                input mem_line_t data);
        for (int i = 0; i < (1 << int'(size)); i++) begin
            shadow[addr + i] = data[8*i +: 8];
        end
    endtask

    function automatic bit valid_cmd(input bus_command_t cmd, input logic [`MEM_XLEN-1:0] addr,
                                     input mem_size_t size);
        int n;
        n = 1 << int'(size);
        if (cmd != BUS_LOAD && cmd != BUS_STORE) begin
            return 1'b0;
        end
        if (addr >= `MEM_SIZE_IN_BYTES) begin
            return 1'b0;
        end
        return (addr & (n - 1)) == 0;
    endfunction

    function automatic mem_tag_t lowest_free(input logic [`NUM_MEM_TAGS:1] used);
        mem_tag_t t;
        t = '0;
        for (int i = 1; i <= `NUM_MEM_TAGS; i++) begin
            if (!used[i] && t == '0) begin
                t = mem_tag_t'(i);
            end
        end
        return t;
    endfunction

    task automatic report_mismatch(input mem_line_t expected, input mem_line_t actual);
        $display("mismatch %s: expected %h actual %h", cur_test, expected, actual);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // comparison process, samples on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : compare
        mem_tag_t exp_tag;
        mem_tag_t rt;
        mem_tag_t rsp;
        if (!arst_n) begin
            outstanding = '0;
            pending     = 0;
            prev_cmd    = BUS_NONE;
        end else begin
            cycle_cnt++;
            exp_tag = lowest_free(outstanding); // tag state before this edge
            rt      = mem2proc_tag;
            rsp     = mem2proc_response;
            if (rt != '0) begin
                last_ret_tag  = rt;
                last_ret_data = mem2proc_data;
                last_latency  = cycle_cnt - resp_cycle[rt];
                if (!outstanding[rt]) begin
                    $display("%s: data returned on tag %0d with no load outstanding", cur_test, rt);
                    errors++;
                end else begin
                    if (mem2proc_data !== exp_data[rt]) begin
                        report_mismatch(exp_data[rt], mem2proc_data);
                    end
                    outstanding[rt] = 1'b0;
                    pending--;
                end
            end
            if (prev_cmd != BUS_NONE) begin
                resp_q.push_back(rsp);
            end
            if (!valid_cmd(prev_cmd, prev_addr, prev_size) && rsp != '0) begin
                $display("%s: command at %h accepted with tag %0d, should be refused",
                         cur_test, prev_addr, rsp);
                errors++;
            end else if (rsp != '0) begin
                if (check_alloc && rsp != exp_tag) begin
                    report_mismatch(exp_tag, rsp);
                end
                resp_cycle[rsp] = cycle_cnt;
                if (prev_cmd == BUS_LOAD) begin
                    if (outstanding[rsp]) begin
                        $display("%s: tag %0d reused while its load is outstanding", cur_test, rsp);
                        errors++;
                    end
                    exp_data[rsp]    = ref_load(prev_addr, prev_size);
                    outstanding[rsp] = 1'b1;
                    pending++;
                    loads_accepted++;
                end else begin
                    write_shadow(prev_addr, prev_size, prev_data);
                end
            end
            prev_cmd  = proc2mem_command;
            prev_addr = proc2mem_addr;
            prev_size = proc2mem_size;
            prev_data = proc2mem_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive(input bus_command_t cmd, input logic [`MEM_XLEN-1:0] addr,
                         input mem_size_t size, input mem_line_t data);
        @(posedge clk);
        proc2mem_command <= cmd;
        proc2mem_addr    <= addr;
        proc2mem_size    <= size;
        proc2mem_data    <= data;
    endtask

    task automatic idle();
        drive(BUS_NONE, '0, BYTE, '0);
    endtask

    // one command, response read on the falling edge after it is registered
    task automatic issue_one(input bus_command_t cmd, input logic [`MEM_XLEN-1:0] addr,
                             input mem_size_t size, input mem_line_t data, output mem_tag_t tag);
        drive(cmd, addr, size, data);
        idle();
        @(negedge clk);
        tag = mem2proc_response;
    endtask

    task automatic check_accepted(input mem_tag_t tag, input logic [`MEM_XLEN-1:0] addr);
        if (tag == '0) begin
            $display("%s: valid command at %h was refused", cur_test, addr);
            errors++;
        end
    endtask

    task automatic expect_refused(input bus_command_t cmd, input logic [`MEM_XLEN-1:0] addr,
                                  input mem_size_t size);
        mem_tag_t tag;
        issue_one(cmd, addr, size, '1, tag);
        if (tag != '0) begin
            report_mismatch('0, tag);
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        idle();
        idle();
        while (pending != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (pending != 0) begin
            $display("%s: timeout after %0d cycles, %0d loads never returned",
                     cur_test, limit, pending);
            errors++;
        end
        repeat (`MEM_LATENCY_IN_CYCLES + 2) @(posedge clk); // store tags run out
    endtask

    task automatic start_test(input string name);
        @(posedge clk);
        cur_test     = name;
        err_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == err_at_start) begin
            $display("test %s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", cur_test, errors - err_at_start);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        mem_tag_t             tag;
        mem_line_t            d;
        logic [`MEM_XLEN-1:0] a;
        mem_size_t            sz;
        int                   n;
        int                   r;
        int                   loads_before;
        void'($urandom(7));
        arst_n           = 1'b0;
        proc2mem_command = BUS_NONE;
        proc2mem_addr    = '0;
        proc2mem_size    = BYTE;
        proc2mem_data    = '0;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        cycle_cnt        = 0;
        loads_accepted   = 0;
        check_alloc      = 1'b0;
        cur_test         = "reset";
        for (int i = 0; i < `MEM_SIZE_IN_BYTES; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        // full line written, read back on the load's tag
        start_test("store_load");
        d = {$urandom, $urandom};
        a = 8 * ($urandom % `MEM_64BIT_LINES);
        issue_one(BUS_STORE, a, DOUBLE, d, tag);
        check_accepted(tag, a);
        issue_one(BUS_LOAD, a, DOUBLE, '0, tag);
        check_accepted(tag, a);
        wait_drain(20);
        if (last_ret_tag != tag) begin
            report_mismatch(tag, last_ret_tag);
        end
        if (last_ret_data !== d) begin
            report_mismatch(d, last_ret_data);
        end
        finish_test();

        start_test("size_merge");
        issue_one(BUS_STORE, 32'h200, DOUBLE, {$urandom, $urandom}, tag);
        for (int i = 0; i < 8; i++) begin
            sz = mem_size_t'($urandom % 3);
            n  = 1 << int'(sz);
            a  = 32'h200 + (($urandom % 8) & ~(n - 1));
            issue_one(BUS_STORE, a, sz, {$urandom, $urandom}, tag);
            check_accepted(tag, a);
        end
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off += (1 << s)) begin
                issue_one(BUS_LOAD, 32'h200 + off, mem_size_t'(s), '0, tag);
                check_accepted(tag, 32'h200 + off);
            end
        end
        wait_drain(50);
        finish_test();

        // latency is far below the tag count, so tags recycle lowest first
        start_test("tag_reuse");
        check_alloc = 1'b1;
        resp_q.delete();
        for (int i = 0; i < 16; i++) begin
            drive(BUS_LOAD, 8 * i, DOUBLE, '0);
        end
        wait_drain(50);
        foreach (resp_q[i]) begin
            if (resp_q[i] == '0) begin
                $display("%s: load %0d refused while tags were free", cur_test, i);
                errors++;
            end
        end
        issue_one(BUS_LOAD, 32'h0, WORD, '0, tag);
        check_accepted(tag, 32'h0);
        wait_drain(20);
        check_alloc = 1'b0;
        finish_test();

        start_test("fixed_latency");
        issue_one(BUS_LOAD, 32'h200, DOUBLE, '0, tag);
        check_accepted(tag, 32'h200);
        wait_drain(20);
        if (last_ret_tag != tag) begin
            report_mismatch(tag, last_ret_tag);
        end
        if (last_latency != `MEM_LATENCY_IN_CYCLES) begin
            report_mismatch(`MEM_LATENCY_IN_CYCLES, last_latency);
        end
        finish_test();

        start_test("refused");
        d = {$urandom, $urandom};
        issue_one(BUS_STORE, 32'h300, DOUBLE, d, tag);
        check_accepted(tag, 32'h300);
        expect_refused(BUS_STORE, 32'h301, HALF);
        expect_refused(BUS_STORE, 32'h302, WORD);
        expect_refused(BUS_STORE, 32'h304, DOUBLE);
        expect_refused(BUS_STORE, `MEM_SIZE_IN_BYTES, BYTE);
        expect_refused(BUS_LOAD, 32'h303, WORD);
        expect_refused(BUS_LOAD, 32'hffff_fff8, DOUBLE);
        expect_refused(BUS_NONE, 32'h300, DOUBLE);
        issue_one(BUS_LOAD, 32'h300, DOUBLE, '0, tag);
        check_accepted(tag, 32'h300);
        wait_drain(20);
        if (last_ret_data !== d) begin
            report_mismatch(d, last_ret_data);
        end
        finish_test();

        start_test("random_mix");
        loads_before = loads_accepted;
        for (int i = 0; i < 300; i++) begin
            r  = $urandom % 10;
            sz = mem_size_t'($urandom % 4);
            n  = 1 << int'(sz);
            a  = ($urandom % 512) & ~(n - 1);
            if (r < 4) begin
                drive(BUS_LOAD, a, sz, '0);
            end else if (r < 8) begin
                drive(BUS_STORE, a, sz, {$urandom, $urandom});
            end else if (r == 8) begin
                drive(BUS_NONE, a, sz, '0);
            end else begin
                // misaligned, or out of range for a byte
                drive(BUS_STORE, (sz == BYTE) ? a + `MEM_SIZE_IN_BYTES : a | 1, sz, '1);
            end
        end
        wait_drain(100);
        if (loads_accepted == loads_before) begin
            $display("%s: no load was accepted during random traffic", cur_test);
            errors++;
        end
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
verilog/mem_pkg.sv
verilog/mem_access_if.sv
verilog/mem_storage.sv
verilog/mem_tag_tracker.sv
verilog/mem_top.sv
bench/mem_sva.sv
bench/mem_tb.sv
